// ==== design/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // tag released by commit
    input  wire logic                    commit_valid_i,
    input  rename_types_pkg::phys_tag_t  commit_tag_i,
    alloc_if.provider                    alloc
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // queue storage
    phys_tag_t fifo_q [FREE_DEPTH];
    // read and write pointers, msb wraps
    free_ptr_t rd_ptr_q;
    free_ptr_t wr_ptr_q;

    // ========================================
    // head of queue
    // ========================================

    // equal pointers including wrap bit means nothing left
    assign alloc.empty    = (rd_ptr_q == wr_ptr_q);
    assign alloc.head_tag = fifo_q[rd_ptr_q[PTR_W-2:0]];
    assign alloc.head_ptr = rd_ptr_q;

    // ========================================
    // pointers
    // ========================================

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_ptr_q <= '0;
            // full at reset, write pointer one lap ahead
            wr_ptr_q <= free_ptr_t'(FREE_DEPTH);
        end else begin
            // rewind to the checkpoint, pop cannot come with it
            if (alloc.restore) begin
                rd_ptr_q <= alloc.restore_ptr;
            end else if (alloc.pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // committed frees stay regardless of restore
            if (commit_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    // ========================================
    // storage
    // ========================================

    always_ff @(posedge clock) begin
        if (reset) begin
            // tags above the arch range start out free
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fifo_q[i] <= phys_tag_t'(ARCH_REGS + i);
            end
        end else if (commit_valid_i) begin
            fifo_q[wr_ptr_q[PTR_W-2:0]] <= commit_tag_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // source and destination lookups
    input  rename_types_pkg::arch_idx_t  src1_i,
    input  rename_types_pkg::arch_idx_t  src2_i,
    input  rename_types_pkg::arch_idx_t  dst_i,
    // writeback
    input  wire logic                    wb_valid_i,
    input  rename_types_pkg::phys_tag_t  wb_tag_i,
    // lookup results
    output rename_types_pkg::phys_tag_t  src1_tag_o,
    output logic                         src1_ready_o,
    output rename_types_pkg::phys_tag_t  src2_tag_o,
    output logic                         src2_ready_o,
    output rename_types_pkg::phys_tag_t  old_tag_o,
    ckpt_if.tbl                          ckpt
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // alias table, entry i belongs to arch reg i
    map_image_t table_q;
    // per-tag record of writebacks, cleared when the tag is handed out again
    logic [PHYS_REGS-1:0] wb_seen_q;

    // writeback on this tag in the current cycle
    function automatic logic wb_hit(input logic wb_valid, input phys_tag_t wb_tag,
                                    input phys_tag_t tag);
        return wb_valid && (wb_tag == tag);
    endfunction

    // ========================================
    // lookups
    // ========================================

    always_comb begin
        src1_tag_o   = table_q[src1_i].tag;
        src2_tag_o   = table_q[src2_i].tag;
        // same-cycle writeback counts as ready
        src1_ready_o = table_q[src1_i].ready | wb_hit(wb_valid_i, wb_tag_i, src1_tag_o);
        src2_ready_o = table_q[src2_i].ready | wb_hit(wb_valid_i, wb_tag_i, src2_tag_o);
        // mapping being displaced by this dispatch
        old_tag_o    = table_q[dst_i].tag;
    end

    assign ckpt.image = table_q;

    // ========================================
    // table update
    // ========================================

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, all values committed
            for (int i = 0; i < ARCH_REGS; i++) begin
                table_q[i].tag   <= phys_tag_t'(i);
                table_q[i].ready <= 1'b1;
            end
            wb_seen_q <= '1;
        end else begin
            if (ckpt.restore) begin
                // reload snapshot, keep readiness gained since it was taken
                for (int i = 0; i < ARCH_REGS; i++) begin
                    table_q[i].tag   <= ckpt.restore_image[i].tag;
                    table_q[i].ready <= ckpt.restore_image[i].ready
                                      | wb_seen_q[ckpt.restore_image[i].tag]
                                      | wb_hit(wb_valid_i, wb_tag_i,
                                               ckpt.restore_image[i].tag);
                end
            end else begin
                // every entry holding the written tag becomes ready
                for (int i = 0; i < ARCH_REGS; i++) begin
                    if (wb_hit(wb_valid_i, wb_tag_i, table_q[i].tag)) begin
                        table_q[i].ready <= 1'b1;
                    end
                end
                // new mapping overrides the writeback on that entry
                if (ckpt.rename_valid) begin
                    table_q[ckpt.rename_arch].tag   <= ckpt.rename_tag;
                    table_q[ckpt.rename_arch].ready <= 1'b0;
                end
            end
            // tag history
            if (wb_valid_i) begin
                wb_seen_q[wb_tag_i] <= 1'b1;
            end
            if (ckpt.rename_valid) begin
                wb_seen_q[ckpt.rename_tag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

    // ========================================
    // rename subsystem sizes
    // ========================================

    // architectural register file
    localparam int ARCH_REGS = 16;
    localparam int ARCH_W    = $clog2(ARCH_REGS);

    // physical register file, one tag per entry
    localparam int PHYS_REGS = 32;
    localparam int PHYS_W    = $clog2(PHYS_REGS);

    // tags left over once every arch reg holds one
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;
    // index bits plus one wrap bit
    localparam int PTR_W      = $clog2(FREE_DEPTH) + 1;

    // r0 reads as zero and is never renamed
    localparam int ZERO_REG = 0;

endpackage

`default_nettype wire

// ==== design/rename_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_control (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // dispatch
    input  wire logic                    disp_valid_i,
    input  rename_types_pkg::arch_idx_t  disp_dst_i,
    input  wire logic                    disp_is_branch_i,
    // recovery
    input  wire logic                    mispredict_i,
    // results
    output rename_types_pkg::phys_tag_t  new_tag_o,
    output logic                         stall_o,
    output logic                         checkpoint_valid_o,
    alloc_if.consumer                    alloc,
    ckpt_if.control                      ckpt
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    logic       needs_tag;
    logic       accept;
    logic       do_restore;
    // checkpoint state
    logic       ckpt_valid_q;
    map_image_t ckpt_image_q;
    free_ptr_t  ckpt_ptr_q;
    // snapshot as it will stand after this dispatch
    map_image_t image_next;
    free_ptr_t  ptr_next;

    // ========================================
    // dispatch acceptance
    // ========================================

    // r0 writes are dropped, no tag needed
    assign needs_tag  = (disp_dst_i != arch_idx_t'(ZERO_REG));
    assign stall_o    = alloc.empty && needs_tag;
    assign accept     = disp_valid_i && !stall_o && !mispredict_i;
    // mispredict only acts on a held checkpoint
    assign do_restore = mispredict_i && ckpt_valid_q;

    assign new_tag_o  = needs_tag ? alloc.head_tag : '0;

    // free list side
    assign alloc.pop         = accept && needs_tag;
    assign alloc.restore     = do_restore;
    assign alloc.restore_ptr = ckpt_ptr_q;

    // table side
    assign ckpt.rename_valid  = alloc.pop;
    assign ckpt.rename_arch   = disp_dst_i;
    assign ckpt.rename_tag    = alloc.head_tag;
    assign ckpt.restore       = do_restore;
    assign ckpt.restore_image = ckpt_image_q;

    assign checkpoint_valid_o = ckpt_valid_q;

    // ========================================
    // checkpoint
    // ========================================

    // patch in the branch's own rename, pointer past its pop
    always_comb begin
        image_next = ckpt.image;
        ptr_next   = alloc.head_ptr;
        if (alloc.pop) begin
            image_next[disp_dst_i] = '{tag: alloc.head_tag, ready: 1'b0};
            ptr_next               = alloc.head_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ckpt_valid_q <= 1'b0;
        end else if (do_restore) begin
            ckpt_valid_q <= 1'b0;
        end else if (accept && disp_is_branch_i) begin
            ckpt_valid_q <= 1'b1;
        end
    end

    // a newer branch simply overwrites
    always_ff @(posedge clock) begin
        if (accept && disp_is_branch_i) begin
            ckpt_image_q <= image_next;
            ckpt_ptr_q   <= ptr_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/rename_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// tag allocation between rename control and the free list
interface alloc_if;
    import rename_types_pkg::*;

    // free list side
    phys_tag_t head_tag;
    logic      empty;
    free_ptr_t head_ptr;
    // control side
    logic      pop;
    logic      restore;
    free_ptr_t restore_ptr;

    // pop only while not empty, popped tag is this cycle's head_tag
    modport provider (output head_tag, empty, head_ptr, input pop, restore, restore_ptr);
    modport consumer (input head_tag, empty, head_ptr, output pop, restore, restore_ptr);
endinterface

// rename writes and checkpoint traffic between control and the alias table
interface ckpt_if;
    import rename_types_pkg::*;

    // live table image
    map_image_t image;
    // rename request, never raised together with restore
    logic       rename_valid;
    arch_idx_t  rename_arch;
    phys_tag_t  rename_tag;
    // checkpoint reload
    logic       restore;
    map_image_t restore_image;

    modport tbl (output image, input rename_valid, rename_arch, rename_tag, restore, restore_image);
    modport control (input image, output rename_valid, rename_arch, rename_tag, restore,
                     restore_image);
endinterface

`default_nettype wire

// ==== design/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_top (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // dispatch
    input  wire logic                    disp_valid_i,
    input  rename_types_pkg::arch_idx_t  disp_dst_i,
    input  wire logic                    disp_is_branch_i,
    input  rename_types_pkg::arch_idx_t  disp_src1_i,
    input  rename_types_pkg::arch_idx_t  disp_src2_i,
    // rename results
    output rename_types_pkg::phys_tag_t  src1_tag_o,
    output logic                         src1_ready_o,
    output rename_types_pkg::phys_tag_t  src2_tag_o,
    output logic                         src2_ready_o,
    output rename_types_pkg::phys_tag_t  new_tag_o,
    output rename_types_pkg::phys_tag_t  old_tag_o,
    output logic                         stall_o,
    // writeback
    input  wire logic                    wb_valid_i,
    input  rename_types_pkg::phys_tag_t  wb_tag_i,
    // commit
    input  wire logic                    commit_valid_i,
    input  rename_types_pkg::phys_tag_t  commit_old_tag_i,
    // recovery
    input  wire logic                    mispredict_i,
    output logic                         checkpoint_valid_o
);

    // ========================================
    // internal buses
    // ========================================

    alloc_if alloc_bus ();
    ckpt_if  ckpt_bus ();

    // alias table
    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .src1_i       (disp_src1_i),
        .src2_i       (disp_src2_i),
        .dst_i        (disp_dst_i),
        .wb_valid_i   (wb_valid_i),
        .wb_tag_i     (wb_tag_i),
        .src1_tag_o   (src1_tag_o),
        .src1_ready_o (src1_ready_o),
        .src2_tag_o   (src2_tag_o),
        .src2_ready_o (src2_ready_o),
        .old_tag_o    (old_tag_o),
        .ckpt         (ckpt_bus.tbl)
    );

    // free tag queue
    free_list u_free_list (
        .clock          (clock),
        .reset          (reset),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_old_tag_i),
        .alloc          (alloc_bus.provider)
    );

    // dispatch, stall and checkpoint
    rename_control u_rename_control (
        .clock              (clock),
        .reset              (reset),
        .disp_valid_i       (disp_valid_i),
        .disp_dst_i         (disp_dst_i),
        .disp_is_branch_i   (disp_is_branch_i),
        .mispredict_i       (mispredict_i),
        .new_tag_o          (new_tag_o),
        .stall_o            (stall_o),
        .checkpoint_valid_o (checkpoint_valid_o),
        .alloc              (alloc_bus.consumer),
        .ckpt               (ckpt_bus.control)
    );

endmodule

`default_nettype wire

// ==== design/rename_types_pkg.sv ====
`default_nettype none

package rename_types_pkg;

    // ========================================
    // rename data types
    // ========================================

    // architectural register index
    typedef logic [rename_cfg_pkg::ARCH_W-1:0] arch_idx_t;

    // physical register tag
    typedef logic [rename_cfg_pkg::PHYS_W-1:0] phys_tag_t;

    // one alias table entry, tag plus value-ready flag
    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } map_entry_t;

    // whole table, entry i at index i
    // 16 entries of 6 bits
    typedef map_entry_t [rename_cfg_pkg::ARCH_REGS-1:0] map_image_t;

    // free list pointer, msb is the wrap bit
    typedef logic [rename_cfg_pkg::PTR_W-1:0] free_ptr_t;

endpackage

`default_nettype wire

// ==== rename_top.f ====
design/rename_cfg_pkg.sv
design/rename_types_pkg.sv
design/rename_if.sv
design/map_table.sv
design/free_list.sv
design/rename_control.sv
design/rename_top.sv
testbench/rename_properties.sv
testbench/rename_tb.sv

// ==== testbench/rename_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_properties (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // free list handshake
    input  wire logic                    pop_i,
    input  wire logic                    empty_i,
    // alias table requests
    input  wire logic                    rename_valid_i,
    input  wire logic                    restore_i,
    // dispatch side
    input  wire logic                    stall_i,
    input  rename_types_pkg::arch_idx_t  dst_i,
    input  wire logic                    checkpoint_valid_i
);
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;

    // number of assertion failures so far
    int fail_count = 0;

    // ========================================
    // rename control rules
    // ========================================

    // no tag is taken from an empty queue
    pop_when_not_empty: assert property (@(posedge clock) disable iff (reset)
        !(pop_i && empty_i))
        else begin
            fail_count++;
            $error("free list popped while empty");
        end

    // restore wins, rename must stay low
    rename_excludes_restore: assert property (@(posedge clock) disable iff (reset)
        !(rename_valid_i && restore_i))
        else begin
            fail_count++;
            $error("rename and restore active in the same cycle");
        end

    // r0 needs no tag so it can never stall
    no_stall_on_r0: assert property (@(posedge clock) disable iff (reset)
        (dst_i == arch_idx_t'(ZERO_REG)) |-> !stall_i)
        else begin
            fail_count++;
            $error("stall raised for a dispatch to r0");
        end

    // the single checkpoint is consumed by its restore
    restore_clears_checkpoint: assert property (@(posedge clock) disable iff (reset)
        restore_i |=> !checkpoint_valid_i)
        else begin
            fail_count++;
            $error("checkpoint still valid after restore");
        end

endmodule

bind rename_control rename_properties u_rename_properties (
    .clock              (clock),
    .reset              (reset),
    .pop_i              (alloc.pop),
    .empty_i            (alloc.empty),
    .rename_valid_i     (ckpt.rename_valid),
    .restore_i          (ckpt.restore),
    .stall_i            (stall_o),
    .dst_i              (disp_dst_i),
    .checkpoint_valid_i (checkpoint_valid_o)
);

`default_nettype wire

// ==== testbench/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_tb;
    import rename_types_pkg::*;

    // stimulus file layout, one test per line
    localparam int MAX_TESTS = 64;
    localparam int NCOL      = 19;
    // op code bits select which outputs are compared
    localparam logic [7:0] OP_SRC   = 8'h01;
    localparam logic [7:0] OP_TAGS  = 8'h02;
    localparam logic [7:0] OP_STALL = 8'h04;

    logic      clock;
    logic      reset;
    // DUT inputs
    logic      disp_valid;
    arch_idx_t disp_dst;
    logic      disp_is_branch;
    arch_idx_t disp_src1;
    arch_idx_t disp_src2;
    logic      wb_valid;
    phys_tag_t wb_tag;
    logic      commit_valid;
    phys_tag_t commit_old_tag;
    logic      mispredict;
    // DUT outputs
    phys_tag_t src1_tag;
    logic      src1_ready;
    phys_tag_t src2_tag;
    logic      src2_ready;
    phys_tag_t new_tag;
    phys_tag_t old_tag;
    logic      stall;
    logic      checkpoint_valid;

    logic [7:0] vec [MAX_TESTS*NCOL];
    int n_tests;
    int cur_test;
    int errors;
    int test_errors;
    int passed;
    int failed;
    int assert_errors;
    int cycles = 0;
    int cycle_limit = 0;

    rename_top i_rename_top (
        .clock              (clock),
        .reset              (reset),
        .disp_valid_i       (disp_valid),
        .disp_dst_i         (disp_dst),
        .disp_is_branch_i   (disp_is_branch),
        .disp_src1_i        (disp_src1),
        .disp_src2_i        (disp_src2),
        .src1_tag_o         (src1_tag),
        .src1_ready_o       (src1_ready),
        .src2_tag_o         (src2_tag),
        .src2_ready_o       (src2_ready),
        .new_tag_o          (new_tag),
        .old_tag_o          (old_tag),
        .stall_o            (stall),
        .wb_valid_i         (wb_valid),
        .wb_tag_i           (wb_tag),
        .commit_valid_i     (commit_valid),
        .commit_old_tag_i   (commit_old_tag),
        .mispredict_i       (mispredict),
        .checkpoint_valid_o (checkpoint_valid)
    );

    // ========================================
    // clock and timeout
    // ========================================

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // ========================================
    // stimulus and checking
    // ========================================

    task automatic check_value(input string what, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: test %0d %s is %0h, expected %0h",
                     $time, cur_test, what, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic drive_idle();
        disp_valid     = 1'b0;
        disp_dst       = '0;
        disp_is_branch = 1'b0;
        disp_src1      = '0;
        disp_src2      = '0;
        wb_valid       = 1'b0;
        wb_tag         = '0;
        commit_valid   = 1'b0;
        commit_old_tag = '0;
        mispredict     = 1'b0;
    endtask

    // columns 1 to 10 are the inputs
    task automatic apply_test(input int t);
        int b;
        b = t * NCOL;
        disp_valid     = vec[b+1][0];
        disp_dst       = arch_idx_t'(vec[b+2]);
        disp_is_branch = vec[b+3][0];
        disp_src1      = arch_idx_t'(vec[b+4]);
        disp_src2      = arch_idx_t'(vec[b+5]);
        wb_valid       = vec[b+6][0];
        wb_tag         = phys_tag_t'(vec[b+7]);
        commit_valid   = vec[b+8][0];
        commit_old_tag = phys_tag_t'(vec[b+9]);
        mispredict     = vec[b+10][0];
    endtask

    // columns 11 to 18 are the expected outputs
    task automatic compare_outputs(input int t);
        int b;
        logic [7:0] op;
        b  = t * NCOL;
        op = vec[b];
        if ((op & OP_SRC) != 0) begin
            check_value("src1_tag", 8'(src1_tag), vec[b+11]);
            check_value("src1_ready", 8'(src1_ready), vec[b+12]);
            check_value("src2_tag", 8'(src2_tag), vec[b+13]);
            check_value("src2_ready", 8'(src2_ready), vec[b+14]);
        end
        if ((op & OP_TAGS) != 0) begin
            check_value("new_tag", 8'(new_tag), vec[b+15]);
            check_value("old_tag", 8'(old_tag), vec[b+16]);
        end
        if ((op & OP_STALL) != 0) begin
            check_value("stall", 8'(stall), vec[b+17]);
        end
        // checkpoint flag on every line
        check_value("checkpoint_valid", 8'(checkpoint_valid), vec[b+18]);
    endtask

    initial begin
        reset = 1'b1;
        drive_idle();
        errors = 0;
        passed = 0;
        failed = 0;
        $readmemh("testbench/rename_tests.txt", vec);
        n_tests = 0;
        while (n_tests < MAX_TESTS && !$isunknown(vec[n_tests*NCOL])) begin
            n_tests++;
        end
        cycle_limit = n_tests * 4 + 20;
        if (n_tests == 0) begin
            $display("no tests were found in testbench/rename_tests.txt");
            errors++;
        end
        // two reset edges, then one line per cycle
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int t = 0; t < n_tests; t++) begin
            cur_test    = t + 1;
            test_errors = 0;
            apply_test(t);
            // outputs settle well before the next edge
            #7;
            compare_outputs(t);
            if (test_errors == 0) begin
                passed++;
                $display("test %0d: ok", cur_test);
            end else begin
                failed++;
                $display("test %0d: %0d mismatches", cur_test, test_errors);
            end
            @(posedge clock);
            #1;
        end
        drive_idle();
        // failed concurrent assertions in the bound checker
        assert_errors = i_rename_top.u_rename_control.u_rename_properties.fail_count;
        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_tests, passed, failed, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rename_tests.txt ====
// op vld dst br s1 s2 wbv wbt cmv cmt mis | s1t s1r s2t s2r new old stall ckv
// op bit0 sources, bit1 new and old tag, bit2 stall, ckv always compared
1 0 0 0 1 2 0 00 0 00 0  01 1 02 1 00 00 0 0
1 0 0 0 0 f 0 00 0 00 0  00 1 0f 1 00 00 0 0
1 0 0 0 7 8 0 00 0 00 0  07 1 08 1 00 00 0 0
7 1 1 0 1 2 0 00 0 00 0  01 1 02 1 10 01 0 0
7 1 2 0 1 3 0 00 0 00 0  10 0 03 1 11 02 0 0
7 1 1 0 1 2 0 00 0 00 0  10 0 11 0 12 10 0 0
7 1 0 0 1 2 0 00 0 00 0  12 0 11 0 00 00 0 0
7 1 3 0 0 1 0 00 0 00 0  00 1 12 0 13 03 0 0
1 0 0 0 1 2 1 12 0 00 0  12 1 11 0 00 00 0 0
1 0 0 0 1 3 0 00 0 00 0  12 1 13 0 00 00 0 0
1 0 0 0 2 2 1 11 0 00 0  11 1 11 1 00 00 0 0
6 1 4 0 0 0 0 00 0 00 0  00 0 00 0 14 04 0 0
6 1 5 0 0 0 0 00 0 00 0  00 0 00 0 15 05 0 0
6 1 6 0 0 0 0 00 0 00 0  00 0 00 0 16 06 0 0
6 1 7 0 0 0 0 00 0 00 0  00 0 00 0 17 07 0 0
6 1 8 0 0 0 0 00 0 00 0  00 0 00 0 18 08 0 0
6 1 9 0 0 0 0 00 0 00 0  00 0 00 0 19 09 0 0
6 1 a 0 0 0 0 00 0 00 0  00 0 00 0 1a 0a 0 0
6 1 b 0 0 0 0 00 0 00 0  00 0 00 0 1b 0b 0 0
6 1 c 0 0 0 0 00 0 00 0  00 0 00 0 1c 0c 0 0
6 1 d 0 0 0 0 00 0 00 0  00 0 00 0 1d 0d 0 0
6 1 e 0 0 0 0 00 0 00 0  00 0 00 0 1e 0e 0 0
6 1 f 0 0 0 0 00 0 00 0  00 0 00 0 1f 0f 0 0
6 1 0 0 0 0 0 00 0 00 0  00 0 00 0 00 00 0 0
4 1 5 0 0 0 0 00 0 00 0  00 0 00 0 00 00 1 0
4 1 5 0 0 0 0 00 1 05 0  00 0 00 0 00 00 1 0
6 1 5 0 0 0 0 00 0 00 0  00 0 00 0 05 15 0 0
0 0 0 0 0 0 0 00 1 01 0  00 0 00 0 00 00 0 0
0 0 0 0 0 0 0 00 1 02 0  00 0 00 0 00 00 0 0
0 0 0 0 0 0 0 00 1 03 0  00 0 00 0 00 00 0 0
7 1 6 1 6 5 0 00 0 00 0  16 0 05 0 01 16 0 0
7 1 6 0 6 5 0 00 0 00 0  01 0 05 0 02 01 0 1
7 1 7 0 6 7 1 01 0 00 0  02 0 17 0 03 17 0 1
1 0 0 0 6 7 0 00 0 00 1  02 0 03 0 00 00 0 1
1 0 0 0 6 7 0 00 0 00 0  01 1 17 0 00 00 0 0
1 0 0 0 5 4 0 00 0 00 0  05 0 14 0 00 00 0 0
7 1 8 0 6 0 0 00 0 00 0  01 1 00 1 02 18 0 0
1 0 0 0 8 6 0 00 0 00 1  02 0 01 1 00 00 0 0
1 0 0 0 8 6 0 00 0 00 0  02 0 01 1 00 00 0 0
